// ==== include/conv_consts.svh ====
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Input image, streamed in raster order.
`define CONV_IMG_W      28
`define CONV_IMG_H      28

// Valid region of the 3x3 convolution.
`define CONV_OUT_W      26
`define CONV_OUT_H      26

`define CONV_NUM_LANES  7
`define CONV_LANE_W     3
`define CONV_WIN_SIZE   9

`define CONV_PIX_W      8
`define CONV_COEF_W     8
`define CONV_BIAS_W     16
`define CONV_ACC_W      24
`define CONV_ADDR_W     10

`endif

// ==== hw/conv_pkg.sv ====
`default_nettype none

`include "conv_consts.svh"

package conv_pkg;

    typedef logic [`CONV_PIX_W-1:0] pixel_t;

    typedef logic signed [`CONV_COEF_W-1:0] tap_t;

    // Row-major, px[0] is the top left pixel.
    typedef struct packed {
        pixel_t [`CONV_WIN_SIZE-1:0] px;
    } window_t;

    typedef struct packed {
        logic [`CONV_WIN_SIZE*`CONV_COEF_W-`CONV_BIAS_W-1:0] pad;
        logic signed [`CONV_BIAS_W-1:0]                      value;
    } coef_bias_t;

    // Same word read as taps or as a bias.
    typedef union packed {
        tap_t [`CONV_WIN_SIZE-1:0] taps;  // Same order as window_t.
        coef_bias_t                bias;
    } coef_payload_u;

    typedef enum logic {
        COEF_TAPS = 1'b0,
        COEF_BIAS = 1'b1
    } coef_kind_e;

    typedef struct packed {
        coef_kind_e                kind;
        logic [`CONV_LANE_W-1:0]   lane;
        coef_payload_u             payload;
    } coef_word_t;

    typedef struct packed {
        logic                      valid;
        logic [`CONV_ACC_W-1:0]    value;
    } lane_result_t;

    typedef lane_result_t [`CONV_NUM_LANES-1:0] lane_bus_t;

endpackage

`default_nettype wire

// ==== hw/window_gen.sv ====
`default_nettype none

`include "conv_consts.svh"

module window_gen
(
    input  wire                clk,
    input  wire                rst,
    input  wire                pixel_valid,
    input  wire conv_pkg::pixel_t  pixel,
    output logic               window_valid,
    output conv_pkg::window_t  window
);

    import conv_pkg::*;

    localparam int COL_W = $clog2(`CONV_IMG_W);
    localparam int ROW_W = $clog2(`CONV_IMG_H);

    localparam logic [COL_W-1:0] COL_LAST = COL_W'(`CONV_IMG_W - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`CONV_IMG_H - 1);
    localparam logic [COL_W-1:0] COL_FIRST_WIN = COL_W'(2);
    localparam logic [ROW_W-1:0] ROW_FIRST_WIN = ROW_W'(2);

    pixel_t line_prev  [`CONV_IMG_W];  // Row r-1.
    pixel_t line_prev2 [`CONV_IMG_W];  // Row r-2.

    logic [COL_W-1:0] col_cnt;
    logic [ROW_W-1:0] row_cnt;

    pixel_t top_px;
    pixel_t mid_px;
    logic   interior;

    assign top_px = line_prev2[col_cnt];
    assign mid_px = line_prev[col_cnt];

    // Bottom right corner of a full window.
    assign interior = (row_cnt >= ROW_FIRST_WIN) && (col_cnt >= COL_FIRST_WIN);

    always_ff @(posedge clk)
    begin
        if (pixel_valid)
        begin
            line_prev2[col_cnt] <= mid_px;  // Rows move up by one.
            line_prev[col_cnt]  <= pixel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            col_cnt <= '0;
            row_cnt <= '0;
        end
        else if (pixel_valid)
        begin
            if (col_cnt == COL_LAST)
            begin
                col_cnt <= '0;
                if (row_cnt == ROW_LAST)
                begin
                    row_cnt <= '0;  // Frame wrap.
                end
                else
                begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
            else
            begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    // Columns slide left, new column enters on the right.
    always_ff @(posedge clk)
    begin
        if (pixel_valid)
        begin
            for (int r = 0; r < 3; r++)
            begin
                window.px[r*3]   <= window.px[r*3+1];
                window.px[r*3+1] <= window.px[r*3+2];
            end
            window.px[2] <= top_px;
            window.px[5] <= mid_px;
            window.px[8] <= pixel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            window_valid <= 1'b0;
        end
        else
        begin
            window_valid <= pixel_valid && interior;
        end
    end

    // Line buffer indexing relies on this.
    a_counters_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (col_cnt < COL_W'(`CONV_IMG_W)) && (row_cnt < ROW_W'(`CONV_IMG_H))
    );

endmodule

`default_nettype wire

// ==== hw/conv_lane.sv ====
`default_nettype none

`include "conv_consts.svh"

module conv_lane
#(
    parameter int LANE_ID = 0
)
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   coef_valid,
    input  wire conv_pkg::coef_word_t  coef,
    input  wire                   window_valid,
    input  wire conv_pkg::window_t     window,
    output conv_pkg::lane_result_t     result
);

    import conv_pkg::*;

    localparam int WIN    = `CONV_WIN_SIZE;
    localparam int ACC_W  = `CONV_ACC_W;
    localparam int BIAS_W = `CONV_BIAS_W;
    localparam int PROD_W = `CONV_PIX_W + `CONV_COEF_W + 1;

    localparam logic [`CONV_LANE_W-1:0] LANE_SEL = `CONV_LANE_W'(LANE_ID);

    tap_t [WIN-1:0]            taps_q;
    logic signed [BIAS_W-1:0]  bias_q;
    logic                      load_hit;

    logic [PROD_W-1:0]         prod_q [WIN];
    logic                      s1_valid;

    logic [ACC_W-1:0]          acc;
    logic                      res_valid_q;
    logic [ACC_W-1:0]          res_value_q;

    assign load_hit = coef_valid && (coef.lane == LANE_SEL);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            taps_q <= '0;
            bias_q <= '0;
        end
        else if (load_hit)
        begin
            if (coef.kind == COEF_TAPS)
            begin
                taps_q <= coef.payload.taps;
            end
            else
            begin
                bias_q <= coef.payload.bias.value;
            end
        end
    end

    // Stage 1, unsigned pixel times signed tap.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < WIN; i++)
        begin
            prod_q[i] <= $signed({1'b0, window.px[i]}) * $signed(taps_q[i]);
        end
    end

    always_comb
    begin
        acc = {{(ACC_W - BIAS_W){bias_q[BIAS_W-1]}}, bias_q};
        for (int i = 0; i < WIN; i++)
        begin
            acc = acc + {{(ACC_W - PROD_W){prod_q[i][PROD_W-1]}}, prod_q[i]};
        end
    end

    // Stage 2, sum plus bias with ReLU.
    always_ff @(posedge clk)
    begin
        res_value_q <= acc[ACC_W-1] ? '0 : acc;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid    <= 1'b0;
            res_valid_q <= 1'b0;
        end
        else
        begin
            s1_valid    <= window_valid;
            res_valid_q <= s1_valid;
        end
    end

    assign result = '{valid: res_valid_q, value: res_value_q};

    // Coefficients must stay still while a frame streams.
    a_no_load_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        !(load_hit && window_valid)
    );

endmodule

`default_nettype wire

// ==== hw/result_store.sv ====
`default_nettype none

`include "conv_consts.svh"

module result_store
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire conv_pkg::lane_bus_t     lane_bus,
    input  wire                          rd_en,
    input  wire [`CONV_ADDR_W-1:0]       rd_addr,
    input  wire [`CONV_LANE_W-1:0]       rd_lane,
    output logic [`CONV_ACC_W-1:0]       rd_data,
    output logic                         frame_done
);

    localparam int DEPTH = `CONV_OUT_W * `CONV_OUT_H;
    localparam int AW    = `CONV_ADDR_W;
    localparam int LW    = `CONV_LANE_W;
    localparam int LANES = `CONV_NUM_LANES;

    localparam logic [AW-1:0] ADDR_LAST = AW'(DEPTH - 1);
    localparam logic [AW-1:0] ADDR_END  = AW'(DEPTH);
    localparam logic [LW-1:0] LANE_END  = LW'(LANES);

    logic [LANES-1:0][`CONV_ACC_W-1:0] mem [DEPTH];

    logic [LANES-1:0][`CONV_ACC_W-1:0] wr_row;
    logic [LANES-1:0]                  lane_valid;
    logic                              wr_en;
    logic [AW-1:0]                     wr_addr;
    logic                              wr_seen;  // Any row written since reset.
    logic                              rd_ok;

    always_comb
    begin
        for (int l = 0; l < LANES; l++)
        begin
            wr_row[l]     = lane_bus[l].value;
            lane_valid[l] = lane_bus[l].valid;
        end
    end

    assign wr_en = lane_valid[0];
    assign rd_ok = wr_seen && (rd_addr < ADDR_END) && (rd_lane < LANE_END);

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_row;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_addr    <= '0;
            wr_seen    <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= wr_en && (wr_addr == ADDR_LAST);
            if (wr_en)
            begin
                wr_seen <= 1'b1;
                wr_addr <= (wr_addr == ADDR_LAST) ? '0 : wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_data <= '0;
        end
        else if (rd_en)
        begin
            rd_data <= rd_ok ? mem[rd_addr][rd_lane] : '0;  // Unwritten or out of range.
        end
    end

    // Lanes share one latency, lane 0 stands for all.
    a_lanes_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (lane_valid == '0) || (lane_valid == '1)
    );

endmodule

`default_nettype wire

// ==== hw/conv_layer_top.sv ====
`default_nettype none

`include "conv_consts.svh"

module conv_layer_top
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pixel_valid,
    input  wire conv_pkg::pixel_t        pixel,
    input  wire                          coef_valid,
    input  wire conv_pkg::coef_word_t    coef,
    input  wire                          rd_en,
    input  wire [`CONV_ADDR_W-1:0]       rd_addr,
    input  wire [`CONV_LANE_W-1:0]       rd_lane,
    output logic [`CONV_ACC_W-1:0]       rd_data,
    output logic                         frame_done
);

    import conv_pkg::*;

    wire            window_valid;
    wire window_t   window;
    wire lane_bus_t lane_bus;

    window_gen window_gen_inst (
        .clk          (clk),
        .rst          (rst),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .window_valid (window_valid),
        .window       (window)
    );

    // One lane per output channel.
    for (genvar i = 0; i < `CONV_NUM_LANES; i++)
    begin : gen_lane
        conv_lane #(.LANE_ID(i)) lane_inst (
            .clk          (clk),
            .rst          (rst),
            .coef_valid   (coef_valid),
            .coef         (coef),
            .window_valid (window_valid),
            .window       (window),
            .result       (lane_bus[i])
        );
    end

    result_store result_inst (
        .clk        (clk),
        .rst        (rst),
        .lane_bus   (lane_bus),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_lane    (rd_lane),
        .rd_data    (rd_data),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// ==== tests/conv_layer_tb.sv ====
`default_nettype none

`include "conv_consts.svh"

module conv_layer_tb;

    import conv_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int DRIVE_DELAY     = 1;
    localparam int NL              = `CONV_NUM_LANES;
    localparam int PIXELS          = `CONV_IMG_W * `CONV_IMG_H;
    localparam int OUTPUTS         = `CONV_OUT_W * `CONV_OUT_H;
    localparam int PAYLOAD_W       = `CONV_WIN_SIZE * `CONV_COEF_W;
    localparam int CENTER_TAP      = 4;
    localparam int TAP_MAG_W       = `CONV_COEF_W - 1;
    localparam int BIAS_MAG_W      = `CONV_BIAS_W - 1;
    localparam int DONE_TIMEOUT    = 100;
    localparam int NUM_FRAMES      = 6;
    // Each frame streams with up to 4 cycles per pixel and is then read back in full.
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (PIXELS * 4 + OUTPUTS * NL) + 2000;

    typedef pixel_t image_t [PIXELS];
    typedef logic [PAYLOAD_W-1:0] taps_t;  // Tap i in bits 8i+7..8i.

    logic                     clk;
    logic                     rst;
    logic                     pixel_valid;
    pixel_t                   pixel;
    logic                     coef_valid;
    coef_word_t               coef;
    logic                     rd_en;
    logic [`CONV_ADDR_W-1:0]  rd_addr;
    logic [`CONV_LANE_W-1:0]  rd_lane;
    logic [`CONV_ACC_W-1:0]   rd_data;
    logic                     frame_done;

    int          seed = 32779;
    int          frames_seen = 0;
    logic        rd_pending = 1'b0;
    logic [31:0] next_exp;
    string       next_name;
    logic [31:0] exp_d;
    string       name_d;

    image_t                     img;
    image_t                     img_saved;
    taps_t                      lane_taps [NL];
    taps_t                      taps_saved [NL];
    logic signed [`CONV_BIAS_W-1:0] lane_bias [NL];
    logic signed [`CONV_BIAS_W-1:0] bias_saved [NL];

    conv_layer_top i_conv_layer_top (
        .clk         (clk),
        .rst         (rst),
        .pixel_valid (pixel_valid),
        .pixel       (pixel),
        .coef_valid  (coef_valid),
        .coef        (coef),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_lane     (rd_lane),
        .rd_data     (rd_data),
        .frame_done  (frame_done)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Expected output at one position, window top left at (row, col).
    function automatic logic [`CONV_ACC_W-1:0] conv_ref(
        input image_t                         image,
        input taps_t                          taps,
        input logic signed [`CONV_BIAS_W-1:0] bias,
        input int                             row,
        input int                             col
    );
        int acc;
        int p;
        int t;
        acc = int'(bias);
        for (int i = 0; i < `CONV_WIN_SIZE; i++)
        begin
            p = int'(image[(row + i / 3) * `CONV_IMG_W + col + i % 3]);
            t = int'($signed(taps[`CONV_COEF_W*i +: `CONV_COEF_W]));
            acc = acc + p * t;
        end
        if (acc < 0)
        begin
            acc = 0;  // ReLU.
        end
        return `CONV_ACC_W'(acc);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %0d actual %0d", test_name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Mismatch");
        end
    endtask

    // Read data is registered, compare half a cycle after it lands.
    always @(posedge clk)
    begin
        rd_pending <= rd_en;
        exp_d      <= next_exp;
        name_d     <= next_name;
    end

    always @(negedge clk)
    begin
        if (rd_pending)
        begin
            check_value(name_d, exp_d, 32'(rd_data));
        end
    end

    always @(negedge clk)
    begin
        if (frame_done === 1'b1)
        begin
            frames_seen++;
        end
    end

    task automatic send_coef(input coef_kind_e kind, input int lane, input taps_t payload);
        @(posedge clk);
        #DRIVE_DELAY;
        coef_valid   = 1'b1;
        coef.kind    = kind;
        coef.lane    = `CONV_LANE_W'(lane);
        coef.payload = payload;
    endtask

    task automatic load_coefs();
        for (int l = 0; l < NL; l++)
        begin
            send_coef(COEF_TAPS, l, lane_taps[l]);
            send_coef(COEF_BIAS, l, {{(PAYLOAD_W - `CONV_BIAS_W){1'b0}}, lane_bias[l]});
        end
        @(posedge clk);
        #DRIVE_DELAY;
        coef_valid = 1'b0;
    endtask

    task automatic stream_frame(input bit gaps);
        int idle;
        for (int i = 0; i < PIXELS; i++)
        begin
            idle = gaps ? int'($unsigned($random(seed)) % 3) : 0;
            repeat (idle)
            begin
                @(posedge clk);
                #DRIVE_DELAY;
                pixel_valid = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            pixel_valid = 1'b1;
            pixel       = img[i];
        end
        @(posedge clk);
        #DRIVE_DELAY;
        pixel_valid = 1'b0;
    endtask

    task automatic wait_frame_done(input string test_name);
        int n;
        n = 0;
        @(negedge clk);
        while (frame_done !== 1'b1 && n < DONE_TIMEOUT)
        begin
            @(negedge clk);
            n++;
        end
        if (frame_done !== 1'b1)
        begin
            fail_run({test_name, ": frame_done did not pulse after the last pixel"});
        end
    endtask

    task automatic run_frame(input string test_name, input bit gaps);
        int count_before;
        count_before = frames_seen;
        stream_frame(gaps);
        wait_frame_done(test_name);
        repeat (2) @(negedge clk);
        check_value({test_name, " frame count"}, 32'(count_before + 1), 32'(frames_seen));
    endtask

    task automatic read_expect(input string test_name, input int addr, input int lane,
                               input logic [31:0] expected);
        @(posedge clk);
        #DRIVE_DELAY;
        rd_en     = 1'b1;
        rd_addr   = `CONV_ADDR_W'(addr);
        rd_lane   = `CONV_LANE_W'(lane);
        next_exp  = expected;
        next_name = test_name;
    endtask

    task automatic drain_reads();
        @(posedge clk);
        #DRIVE_DELAY;
        rd_en = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic check_frame(input string test_name, input bit identity);
        int r;
        int c;
        logic [31:0] expected;
        for (int a = 0; a < OUTPUTS; a++)
        begin
            r = a / `CONV_OUT_W;
            c = a % `CONV_OUT_W;
            for (int l = 0; l < NL; l++)
            begin
                if (identity)
                begin
                    expected = 32'(img[(r + 1) * `CONV_IMG_W + c + 1]);  // Center pixel.
                end
                else
                begin
                    expected = 32'(conv_ref(img, lane_taps[l], lane_bias[l], r, c));
                end
                read_expect(test_name, a, l, expected);
            end
        end
        drain_reads();
    endtask

    task automatic randomize_image();
        for (int i = 0; i < PIXELS; i++)
        begin
            img[i] = `CONV_PIX_W'($random(seed));
        end
    endtask

    task automatic randomize_coefs();
        for (int l = 0; l < NL; l++)
        begin
            for (int t = 0; t < `CONV_WIN_SIZE; t++)
            begin
                lane_taps[l][`CONV_COEF_W*t +: `CONV_COEF_W] = `CONV_COEF_W'($random(seed));
            end
            lane_bias[l] = `CONV_BIAS_W'($random(seed));
        end
    endtask

    initial
    begin
        rst         = 1'b1;
        pixel_valid = 1'b0;
        pixel       = '0;
        coef_valid  = 1'b0;
        coef        = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        rd_lane     = '0;
        next_exp    = '0;
        next_name   = "";
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        repeat (20)
        begin
            @(negedge clk);
            check_value("reset_frame_done", 32'd0, 32'(frame_done));
        end
        for (int l = 0; l < NL; l++)
        begin
            read_expect("reset_read", 0, l, 32'd0);
            read_expect("reset_read", OUTPUTS - 1, l, 32'd0);
        end
        drain_reads();

        for (int l = 0; l < NL; l++)
        begin
            lane_taps[l] = '0;
            lane_taps[l][`CONV_COEF_W*CENTER_TAP +: `CONV_COEF_W] = `CONV_COEF_W'(1);
            lane_bias[l] = '0;
        end
        for (int i = 0; i < PIXELS; i++)
        begin
            img[i] = `CONV_PIX_W'(i);  // Ramp.
        end
        load_coefs();
        run_frame("identity", 1'b0);
        check_frame("identity", 1'b1);

        randomize_image();
        randomize_coefs();
        img_saved  = img;
        taps_saved = lane_taps;
        bias_saved = lane_bias;
        load_coefs();
        run_frame("random", 1'b0);
        check_frame("random", 1'b0);

        randomize_image();
        randomize_coefs();
        for (int t = 0; t < `CONV_WIN_SIZE; t++)
        begin
            lane_taps[0][`CONV_COEF_W*t +: `CONV_COEF_W] = {1'b1, TAP_MAG_W'($random(seed))};
        end
        lane_bias[0] = {1'b1, BIAS_MAG_W'($random(seed))};
        lane_bias[1] = 16'sd30000;
        load_coefs();
        run_frame("relu", 1'b0);
        check_frame("relu", 1'b0);

        img       = img_saved;
        lane_taps = taps_saved;
        lane_bias = bias_saved;
        load_coefs();
        run_frame("gaps", 1'b1);
        check_frame("gaps", 1'b0);

        // Second frame follows the first with only a reload in between.
        randomize_image();
        randomize_coefs();
        load_coefs();
        run_frame("wrap_first", 1'b0);
        randomize_image();
        randomize_coefs();
        load_coefs();
        run_frame("wrap_second", 1'b0);
        check_frame("wrap_second", 1'b0);

        $display("All tests passed!");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
hw/conv_pkg.sv
hw/window_gen.sv
hw/conv_lane.sv
hw/result_store.sv
hw/conv_layer_top.sv
tests/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the convolution layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --assert --top-module conv_layer_tb -f verilog.f -o conv_layer_sim \
    && ./obj_dir/conv_layer_sim > "$LOG" 2>&1 \
    || echo "Build or simulation exited with an error status" >> "$LOG"
cat "$LOG"
grep -q 'Test failures found' "$LOG" && { echo "FAIL"; exit 1; }
grep -q 'All tests passed!' "$LOG" || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
exit 0
